//--- project.f
+incdir+.
proxy_test_pkg.sv
proxy_ram.sv
indirect_reg_file.sv
burst_counter.sv
proxy_fsm.sv
proxy_test.sv
proxy_test_properties.sv
proxy_test_tb.sv

//--- Bender.yml
package:
  name: proxy_test

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - proxy_test_pkg.sv
      - proxy_ram.sv
      - indirect_reg_file.sv
      - burst_counter.sv
      - proxy_fsm.sv
      - proxy_test.sv
  - target: test
    include_dirs:
      - .
    files:
      - proxy_test_properties.sv
      - proxy_test_tb.sv

//--- proxy_test_tb.sv
`timescale 1ns/10ps
`include "proxy_test_macros.svh"

module proxy_test_tb;

    localparam int CLK_PERIOD = 8;
    localparam int N_TRIG     = 8;
    localparam int N_WORDS    = 16;
    localparam int N_FILLS    = 4;
    localparam int MAX_FILL   = 24;
    localparam int DEPTH      = `PROXY_MEM_DEPTH;
    // Commands issued by the sequence below
    localparam int N_CMDS     = 8 + 3 * N_TRIG + 2 * N_WORDS + N_FILLS * (MAX_FILL + 5) + 11;

    logic                       clk;
    logic                       srst;
    logic                       i_req;
    proxy_test_pkg::proxy_cmd_t i_cmd;
    logic                       o_ack;
    proxy_test_pkg::proxy_rsp_t o_rsp;

    logic [31:0]                lcg_state = 32'd47124;
    logic [`PROXY_DATA_WID-1:0] mdl_mem [DEPTH];
    logic [`PROXY_DATA_WID-1:0] mdl_trigger = '0;
    int                         trig_count = 0;
    string                      name_q [$];
    logic [63:0]                exp_q [$];
    logic [63:0]                act_q [$];
    event                       rsp_ready;
    int                         addrs [N_WORDS];

    proxy_test proxy_test_i (
        .clk   ( clk ),
        .srst  ( srst ),
        .i_req ( i_req ),
        .i_cmd ( i_cmd ),
        .o_ack ( o_ack ),
        .o_rsp ( o_rsp )
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // Random numbers, reference model and compare
    // ------------------------------------------------------------------------
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic int rand_below(input int n);
        return int'((lcg_next() >> 8) % n);
    endfunction

    // Expected reply and latency in clocks
    // Model state follows the command
    function automatic proxy_test_pkg::proxy_rsp_t model_cmd(
        input  proxy_test_pkg::proxy_cmd_t cmd,
        output int                         lat
    );
        proxy_test_pkg::proxy_rsp_t rsp;
        int a;
        int n;
        rsp = '0;
        lat = 2;
        a   = cmd.addr;
        n   = cmd.len;
        case (cmd.op)
            proxy_test_pkg::OP_REG_WR: begin
                if (cmd.addr[1:0] == `REG_IDX_TRIGGER) begin
                    mdl_trigger = cmd.data;
                    trig_count++;
                end else begin
                    rsp.err = 1'b1;
                end
            end
            proxy_test_pkg::OP_REG_RD: begin
                case (cmd.addr[1:0])
                    `REG_IDX_PRE:     rsp.data = `REG_PRE_VALUE;
                    `REG_IDX_POST:    rsp.data = `REG_POST_VALUE;
                    `REG_IDX_TRIGGER: rsp.data = mdl_trigger;
                    // Write count on top of the last trigger's low 24 bits
                    default:          rsp.data = {trig_count[7:0], mdl_trigger[23:0]};
                endcase
            end
            default: begin
                if (a >= DEPTH || (cmd.op == proxy_test_pkg::OP_MEM_FILL && a + n > DEPTH)) begin
                    rsp.err = 1'b1;
                end else if (cmd.op == proxy_test_pkg::OP_MEM_WR) begin
                    mdl_mem[a] = cmd.data;
                end else if (cmd.op == proxy_test_pkg::OP_MEM_RD) begin
                    rsp.data = mdl_mem[a];
                    lat      = 3;
                end else begin
                    for (int i = 0; i < n; i++) begin
                        mdl_mem[a + i] = cmd.data;
                    end
                    if (n > 0) begin
                        lat = n + 2;
                    end
                end
            end
        endcase
        return rsp;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    initial begin
        forever begin
            @(rsp_ready);
            while (act_q.size() > 0) begin
                check_value(name_q.pop_front(), exp_q.pop_front(), act_q.pop_front());
            end
        end
    end

    // Stop at the first failing assertion
    initial begin
        wait (proxy_test_i.proxy_fsm_i.proxy_test_properties_i.fail_cnt != 0);
        $display("An assertion on the handshake or reset behavior failed");
        $display("TEST RESULT: FAIL");
        $fatal(1, "Assertion failure");
    end

    // Four-phase handshake for one command
    task automatic run_cmd(input string name, input proxy_test_pkg::op_e op, input int addr,
                           input logic [31:0] data, input int len);
        proxy_test_pkg::proxy_cmd_t cmd;
        proxy_test_pkg::proxy_rsp_t exp_rsp;
        int                         exp_lat;
        int                         cycles;
        cmd.op   = op;
        cmd.addr = addr[`PROXY_ADDR_WID-1:0];
        cmd.data = data;
        cmd.len  = len[`PROXY_LEN_WID-1:0];
        @(negedge clk);
        i_cmd = cmd;
        @(negedge clk);
        i_req  = 1'b1;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!o_ack);
        exp_rsp = model_cmd(cmd, exp_lat);
        name_q.push_back({name, " reply"});
        exp_q.push_back(64'(exp_rsp));
        act_q.push_back(64'(o_rsp));
        name_q.push_back({name, " latency"});
        exp_q.push_back(64'(exp_lat));
        act_q.push_back(64'(cycles - 1));
        -> rsp_ready;
        i_req = 1'b0;
        while (o_ack) begin
            @(negedge clk);
        end
    endtask

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    initial begin
        int base;
        int len;
        int j;
        int tmp;
        srst  = 1'b1;
        i_req = 1'b0;
        i_cmd = '0;
        repeat (2) @(negedge clk);
        srst = 1'b0;

        run_cmd("read PRE", proxy_test_pkg::OP_REG_RD, `REG_IDX_PRE, '0, 0);
        run_cmd("read POST", proxy_test_pkg::OP_REG_RD, `REG_IDX_POST, '0, 0);
        run_cmd("write PRE", proxy_test_pkg::OP_REG_WR, `REG_IDX_PRE, lcg_next(), 0);
        run_cmd("write POST", proxy_test_pkg::OP_REG_WR, `REG_IDX_POST, lcg_next(), 0);
        run_cmd("write STATUS", proxy_test_pkg::OP_REG_WR, `REG_IDX_STATUS, lcg_next(), 0);
        run_cmd("reread PRE", proxy_test_pkg::OP_REG_RD, `REG_IDX_PRE, '0, 0);
        run_cmd("reread POST", proxy_test_pkg::OP_REG_RD, `REG_IDX_POST, '0, 0);
        run_cmd("read STATUS", proxy_test_pkg::OP_REG_RD, `REG_IDX_STATUS, '0, 0);

        for (int i = 0; i < N_TRIG; i++) begin
            run_cmd("write TRIGGER", proxy_test_pkg::OP_REG_WR, `REG_IDX_TRIGGER, lcg_next(), 0);
            run_cmd("read TRIGGER", proxy_test_pkg::OP_REG_RD, `REG_IDX_TRIGGER, '0, 0);
            run_cmd("read STATUS", proxy_test_pkg::OP_REG_RD, `REG_IDX_STATUS, '0, 0);
        end

        for (int i = 0; i < N_WORDS; i++) begin
            addrs[i] = rand_below(DEPTH);
            run_cmd("memory write", proxy_test_pkg::OP_MEM_WR, addrs[i], lcg_next(), 0);
        end
        // Read back in shuffled order
        for (int i = N_WORDS - 1; i > 0; i--) begin
            j        = rand_below(i + 1);
            tmp      = addrs[i];
            addrs[i] = addrs[j];
            addrs[j] = tmp;
        end
        for (int i = 0; i < N_WORDS; i++) begin
            run_cmd("memory read", proxy_test_pkg::OP_MEM_RD, addrs[i], '0, 0);
        end

        // First fill has length zero
        // Guard words sit on both sides of each fill
        for (int f = 0; f < N_FILLS; f++) begin
            len  = (f == 0) ? 0 : 1 + rand_below(MAX_FILL);
            base = 1 + rand_below(DEPTH - MAX_FILL - 2);
            run_cmd("guard low", proxy_test_pkg::OP_MEM_WR, base - 1, lcg_next(), 0);
            run_cmd("guard high", proxy_test_pkg::OP_MEM_WR, base + len, lcg_next(), 0);
            run_cmd("memory fill", proxy_test_pkg::OP_MEM_FILL, base, lcg_next(), len);
            for (int k = base - 1; k <= base + len; k++) begin
                run_cmd("fill readback", proxy_test_pkg::OP_MEM_RD, k, '0, 0);
            end
        end

        // Out of range commands alias onto words that hold known data
        run_cmd("fill to top", proxy_test_pkg::OP_MEM_FILL, DEPTH - 4, lcg_next(), 4);
        run_cmd("write past depth", proxy_test_pkg::OP_MEM_WR, DEPTH + addrs[0], lcg_next(), 0);
        run_cmd("read past depth", proxy_test_pkg::OP_MEM_RD, DEPTH + addrs[1], '0, 0);
        run_cmd("fill past depth", proxy_test_pkg::OP_MEM_FILL, DEPTH + addrs[2], lcg_next(), 3);
        run_cmd("fill over top", proxy_test_pkg::OP_MEM_FILL, DEPTH - 3, lcg_next(), 5);
        run_cmd("range readback", proxy_test_pkg::OP_MEM_RD, addrs[0], '0, 0);
        run_cmd("range readback", proxy_test_pkg::OP_MEM_RD, addrs[2], '0, 0);
        for (int k = DEPTH - 4; k < DEPTH; k++) begin
            run_cmd("top readback", proxy_test_pkg::OP_MEM_RD, k, '0, 0);
        end

        @(negedge clk);
        $display("TEST RESULT: PASS");
        $finish;
    end

    initial begin
        #(N_CMDS * (MAX_FILL + 10) * CLK_PERIOD);
        $display("Timeout: the command sequence did not finish in the allowed time");
        $display("TEST RESULT: FAIL");
        $fatal(1, "Watchdog expired");
    end

endmodule

//--- proxy_test_properties.sv
`timescale 1ns/10ps

module proxy_test_properties (
    input logic                       clk,
    input logic                       srst,
    input logic                       i_req,
    input logic                       i_ack,
    input proxy_test_pkg::proxy_rsp_t i_rsp,
    input proxy_test_pkg::state_e     i_state
);

    int fail_cnt = 0;

    // Reset leaves the sequencer idle with ack low
    reset_idle: assert property (@(posedge clk)
        srst |=> !i_ack && i_state == proxy_test_pkg::S_IDLE)
        else begin
            fail_cnt++;
            $error("ack or state not cleared by reset");
        end

    // Ack only answers a pending request
    ack_needs_req: assert property (@(posedge clk) disable iff (srst)
        (!i_req && !i_ack) |=> !i_ack)
        else begin
            fail_cnt++;
            $error("ack rose while req was low");
        end

    rsp_stable: assert property (@(posedge clk) disable iff (srst)
        (i_ack && $past(i_ack)) |-> $stable(i_rsp))
        else begin
            fail_cnt++;
            $error("reply changed while ack was high");
        end

endmodule

bind proxy_fsm proxy_test_properties proxy_test_properties_i (
    .clk     ( clk ),
    .srst    ( srst ),
    .i_req   ( i_req ),
    .i_ack   ( o_ack ),
    .i_rsp   ( o_rsp ),
    .i_state ( state_q )
);

//--- proxy_test.sv
`timescale 1ns/10ps
`include "proxy_test_macros.svh"

module proxy_test (
    input  logic                       clk,
    input  logic                       srst,
    input  logic                       i_req,
    input  proxy_test_pkg::proxy_cmd_t i_cmd,
    output logic                       o_ack,
    output proxy_test_pkg::proxy_rsp_t o_rsp
);

    proxy_test_pkg::reg_access_t reg_access;
    logic [`PROXY_DATA_WID-1:0]  reg_rdata;
    logic                        reg_err;
    proxy_test_pkg::ram_access_t ram_access;
    logic [`PROXY_DATA_WID-1:0]  ram_rdata;
    logic                        cnt_load;
    logic                        cnt_step;
    logic                        cnt_last;
    logic [`PROXY_LEN_WID-1:0]   cnt_len;
    logic [`PROXY_LEN_WID-1:0]   cnt_offset;

    // ------------------------------------------------------------------------
    // Command sequencer
    // ------------------------------------------------------------------------
    proxy_fsm proxy_fsm_i (
        .clk          ( clk ),
        .srst         ( srst ),
        .i_req        ( i_req ),
        .i_cmd        ( i_cmd ),
        .o_ack        ( o_ack ),
        .o_rsp        ( o_rsp ),
        .o_reg        ( reg_access ),
        .i_reg_rdata  ( reg_rdata ),
        .i_reg_err    ( reg_err ),
        .o_ram        ( ram_access ),
        .i_ram_rdata  ( ram_rdata ),
        .o_cnt_load   ( cnt_load ),
        .o_cnt_step   ( cnt_step ),
        .o_cnt_len    ( cnt_len ),
        .i_cnt_offset ( cnt_offset ),
        .i_cnt_last   ( cnt_last )
    );

    burst_counter burst_counter_i (
        .clk      ( clk ),
        .srst     ( srst ),
        .i_load   ( cnt_load ),
        .i_step   ( cnt_step ),
        .i_len    ( cnt_len ),
        .o_offset ( cnt_offset ),
        .o_last   ( cnt_last )
    );

    // ------------------------------------------------------------------------
    // Register block and word RAM
    // ------------------------------------------------------------------------
    indirect_reg_file indirect_reg_file_i (
        .clk      ( clk ),
        .srst     ( srst ),
        .i_access ( reg_access ),
        .o_rdata  ( reg_rdata ),
        .o_err    ( reg_err )
    );

    proxy_ram proxy_ram_i (
        .clk      ( clk ),
        .i_access ( ram_access ),
        .o_rdata  ( ram_rdata )
    );

endmodule

//--- proxy_fsm.sv
`timescale 1ns/10ps
`include "proxy_test_macros.svh"

module proxy_fsm (
    input  logic                        clk,
    input  logic                        srst,
    input  logic                        i_req,
    input  proxy_test_pkg::proxy_cmd_t  i_cmd,
    output logic                        o_ack,
    output proxy_test_pkg::proxy_rsp_t  o_rsp,
    output proxy_test_pkg::reg_access_t o_reg,
    input  logic [`PROXY_DATA_WID-1:0]  i_reg_rdata,
    input  logic                        i_reg_err,
    output proxy_test_pkg::ram_access_t o_ram,
    input  logic [`PROXY_DATA_WID-1:0]  i_ram_rdata,
    output logic                        o_cnt_load,
    output logic                        o_cnt_step,
    output logic [`PROXY_LEN_WID-1:0]   o_cnt_len,
    input  logic [`PROXY_LEN_WID-1:0]   i_cnt_offset,
    input  logic                        i_cnt_last
);

    proxy_test_pkg::state_e          state_q;
    proxy_test_pkg::state_e          decode_nxt;
    proxy_test_pkg::proxy_cmd_t      cmd_q;
    proxy_test_pkg::proxy_rsp_t      rsp_q;
    proxy_test_pkg::proxy_rsp_t      rsp_nxt;
    logic                            ack_q;
    logic                            done;
    logic                            is_mem;
    logic                            bad_op;
    logic                            cmd_err;
    logic [`PROXY_ADDR_WID:0]        fill_end;
    logic [`PROXY_MEM_ADDR_WID-1:0]  fill_offset;

    // ------------------------------------------------------------------------
    // Decode and memory range check
    // ------------------------------------------------------------------------
    assign fill_end = {1'b0, cmd_q.addr}
                    + {{(`PROXY_ADDR_WID + 1 - `PROXY_LEN_WID){1'b0}}, cmd_q.len};

    always_comb begin
        is_mem = 1'b0;
        bad_op = 1'b0;
        case (cmd_q.op)
            proxy_test_pkg::OP_REG_WR,
            proxy_test_pkg::OP_REG_RD:   is_mem = 1'b0;
            proxy_test_pkg::OP_MEM_WR,
            proxy_test_pkg::OP_MEM_RD,
            proxy_test_pkg::OP_MEM_FILL: is_mem = 1'b1;
            default:                     bad_op = 1'b1;
        endcase
        // Fill may end exactly at the top of the RAM
        cmd_err = bad_op || (is_mem && ((cmd_q.addr >= `PROXY_MEM_DEPTH) ||
                  (cmd_q.op == proxy_test_pkg::OP_MEM_FILL && fill_end > `PROXY_MEM_DEPTH)));

        if (cmd_err) begin
            decode_nxt = proxy_test_pkg::S_DONE;
        end else begin
            case (cmd_q.op)
                proxy_test_pkg::OP_MEM_WR: decode_nxt = proxy_test_pkg::S_MEM_WR;
                proxy_test_pkg::OP_MEM_RD: decode_nxt = proxy_test_pkg::S_MEM_RD;
                proxy_test_pkg::OP_MEM_FILL: begin
                    // Zero-length fill answers without touching the RAM
                    decode_nxt = (cmd_q.len == '0) ? proxy_test_pkg::S_DONE
                                                   : proxy_test_pkg::S_FILL_LOAD;
                end
                default: decode_nxt = proxy_test_pkg::S_REG;
            endcase
        end
    end

    // Reply for the states that finish a command
    always_comb begin
        done    = 1'b0;
        rsp_nxt = '0;
        case (state_q)
            proxy_test_pkg::S_REG: begin
                done         = 1'b1;
                rsp_nxt.data = i_reg_rdata;
                rsp_nxt.err  = i_reg_err;
            end
            proxy_test_pkg::S_MEM_WR: done = 1'b1;
            proxy_test_pkg::S_MEM_WAIT: begin
                done         = 1'b1;
                rsp_nxt.data = i_ram_rdata;
            end
            proxy_test_pkg::S_FILL: done = i_cnt_last;
            proxy_test_pkg::S_DONE: begin
                done        = 1'b1;
                rsp_nxt.err = cmd_err;
            end
            default: done = 1'b0;
        endcase
    end

    // ------------------------------------------------------------------------
    // State and handshake
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            state_q <= proxy_test_pkg::S_IDLE;
            ack_q   <= 1'b0;
        end else begin
            case (state_q)
                proxy_test_pkg::S_IDLE: begin
                    if (i_req) begin
                        state_q <= proxy_test_pkg::S_DECODE;
                    end
                end
                proxy_test_pkg::S_DECODE:    state_q <= decode_nxt;
                proxy_test_pkg::S_MEM_RD:    state_q <= proxy_test_pkg::S_MEM_WAIT;
                proxy_test_pkg::S_FILL_LOAD: state_q <= proxy_test_pkg::S_FILL;
                proxy_test_pkg::S_ACK: begin
                    // Hold ack until the host drops req
                    if (!i_req) begin
                        ack_q   <= 1'b0;
                        state_q <= proxy_test_pkg::S_IDLE;
                    end
                end
                default: begin
                    if (done) begin
                        ack_q   <= 1'b1;
                        state_q <= proxy_test_pkg::S_ACK;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == proxy_test_pkg::S_IDLE && i_req) begin
            cmd_q <= i_cmd;
        end
        if (done) begin
            rsp_q <= rsp_nxt;
        end
    end

    assign o_ack = ack_q;
    assign o_rsp = rsp_q;

    // ------------------------------------------------------------------------
    // Data module steering
    // ------------------------------------------------------------------------
    assign fill_offset = (state_q == proxy_test_pkg::S_FILL)
                       ? {{(`PROXY_MEM_ADDR_WID - `PROXY_LEN_WID){1'b0}}, i_cnt_offset}
                       : '0;

    assign o_reg.wr   = (state_q == proxy_test_pkg::S_REG) &&
                        (cmd_q.op == proxy_test_pkg::OP_REG_WR);
    assign o_reg.rd   = (state_q == proxy_test_pkg::S_REG) &&
                        (cmd_q.op == proxy_test_pkg::OP_REG_RD);
    assign o_reg.idx  = cmd_q.addr[1:0];
    assign o_reg.data = cmd_q.data;

    assign o_ram.en   = (state_q == proxy_test_pkg::S_MEM_WR) ||
                        (state_q == proxy_test_pkg::S_MEM_RD) ||
                        (state_q == proxy_test_pkg::S_FILL);
    assign o_ram.we   = (state_q == proxy_test_pkg::S_MEM_WR) ||
                        (state_q == proxy_test_pkg::S_FILL);
    assign o_ram.addr = cmd_q.addr[`PROXY_MEM_ADDR_WID-1:0] + fill_offset;
    assign o_ram.data = cmd_q.data;

    assign o_cnt_load = (state_q == proxy_test_pkg::S_FILL_LOAD);
    assign o_cnt_step = (state_q == proxy_test_pkg::S_FILL);
    assign o_cnt_len  = cmd_q.len;

endmodule

//--- burst_counter.sv
`timescale 1ns/10ps
`include "proxy_test_macros.svh"

module burst_counter (
    input  logic                      clk,
    input  logic                      srst,
    input  logic                      i_load,
    input  logic                      i_step,
    input  logic [`PROXY_LEN_WID-1:0] i_len,
    output logic [`PROXY_LEN_WID-1:0] o_offset,
    output logic                      o_last
);

    logic [`PROXY_LEN_WID-1:0] len_q;
    logic [`PROXY_LEN_WID-1:0] offset_q;
    logic [`PROXY_LEN_WID:0]   next_cnt;

    // One spare bit so the compare never wraps
    assign next_cnt = {1'b0, offset_q} + {{`PROXY_LEN_WID{1'b0}}, 1'b1};

    always_ff @(posedge clk) begin
        if (srst) begin
            len_q    <= '0;
            offset_q <= '0;
        end else if (i_load) begin
            len_q    <= i_len;
            offset_q <= '0;
        end else if (i_step) begin
            offset_q <= next_cnt[`PROXY_LEN_WID-1:0];
        end
    end

    assign o_offset = offset_q;
    // Current word is the final one of the run
    assign o_last   = (next_cnt == {1'b0, len_q});

endmodule

//--- indirect_reg_file.sv
`timescale 1ns/10ps
`include "proxy_test_macros.svh"

module indirect_reg_file (
    input  logic                        clk,
    input  logic                        srst,
    input  proxy_test_pkg::reg_access_t i_access,
    output logic [`PROXY_DATA_WID-1:0]  o_rdata,
    output logic                        o_err
);

    logic [`PROXY_DATA_WID-1:0] trigger_q;
    logic [`PROXY_DATA_WID-1:0] status_q;
    logic                       trig_wr;

    assign trig_wr = i_access.wr && (i_access.idx == `REG_IDX_TRIGGER);

    // Only the trigger register accepts writes
    assign o_err = i_access.wr && !trig_wr;

    // Status keeps a wrapping write count over the last trigger's low bits
    always_ff @(posedge clk) begin
        if (srst) begin
            trigger_q <= '0;
            status_q  <= '0;
        end else if (trig_wr) begin
            trigger_q <= i_access.data;
            status_q  <= {status_q[31:24] + 8'd1, i_access.data[23:0]};
        end
    end

    always_comb begin
        o_rdata = '0;
        if (i_access.rd) begin
            case (i_access.idx)
                `REG_IDX_PRE:     o_rdata = `REG_PRE_VALUE;
                `REG_IDX_POST:    o_rdata = `REG_POST_VALUE;
                `REG_IDX_TRIGGER: o_rdata = trigger_q;
                `REG_IDX_STATUS:  o_rdata = status_q;
                default:          o_rdata = '0;
            endcase
        end
    end

endmodule

//--- proxy_ram.sv
`timescale 1ns/10ps
`include "proxy_test_macros.svh"

module proxy_ram (
    input  logic                        clk,
    input  proxy_test_pkg::ram_access_t i_access,
    output logic [`PROXY_DATA_WID-1:0]  o_rdata
);

    logic [`PROXY_DATA_WID-1:0] mem [`PROXY_MEM_DEPTH];

    // Single port, write or registered read per cycle
    always_ff @(posedge clk) begin
        if (i_access.en) begin
            if (i_access.we) begin
                mem[i_access.addr] <= i_access.data;
            end else begin
                o_rdata <= mem[i_access.addr];
            end
        end
    end

endmodule

//--- proxy_test_pkg.sv
`include "proxy_test_macros.svh"

package proxy_test_pkg;

    // Host opcodes
    typedef enum logic [2:0] {
        OP_REG_WR   = 3'd0,
        OP_REG_RD   = 3'd1,
        OP_MEM_WR   = 3'd2,
        OP_MEM_RD   = 3'd3,
        OP_MEM_FILL = 3'd4
    } op_e;

    // Command FSM states
    typedef enum logic [3:0] {
        S_IDLE,
        S_DECODE,
        S_REG,
        S_MEM_WR,
        S_MEM_RD,
        S_MEM_WAIT,
        S_FILL_LOAD,
        S_FILL,
        S_DONE,
        S_ACK
    } state_e;

    typedef struct packed {
        op_e                        op;
        logic [`PROXY_ADDR_WID-1:0] addr;
        logic [`PROXY_DATA_WID-1:0] data;
        logic [`PROXY_LEN_WID-1:0]  len;
    } proxy_cmd_t;

    typedef struct packed {
        logic [`PROXY_DATA_WID-1:0] data;
        logic                       err;
    } proxy_rsp_t;

    typedef struct packed {
        logic                       wr;
        logic                       rd;
        logic [1:0]                 idx;
        logic [`PROXY_DATA_WID-1:0] data;
    } reg_access_t;

    typedef struct packed {
        logic                           en;
        logic                           we;
        logic [`PROXY_MEM_ADDR_WID-1:0] addr;
        logic [`PROXY_DATA_WID-1:0]     data;
    } ram_access_t;

endpackage

//--- proxy_test_macros.svh
`ifndef PROXY_TEST_MACROS_SVH
`define PROXY_TEST_MACROS_SVH

// Host command field widths
`define PROXY_DATA_WID      32
`define PROXY_ADDR_WID      12
`define PROXY_LEN_WID       8

// Word RAM geometry
`define PROXY_MEM_DEPTH     1024
`define PROXY_MEM_ADDR_WID  10

// Indirect register indices
`define REG_IDX_PRE         2'd0
`define REG_IDX_POST        2'd1
`define REG_IDX_TRIGGER     2'd2
`define REG_IDX_STATUS      2'd3

// Identifier words, " PRE" and "POST" in ASCII
`define REG_PRE_VALUE       32'h20505245
`define REG_POST_VALUE      32'h504F5354

`endif
